/* common/rv_pkg.sv */
// --------------------------------------
// RV32I execute-side shared definitions
// Opcodes, flow and result-control codes
// --------------------------------------

package rv_pkg;

    // Widths
    localparam int cpu_width      = 32;
    localparam int reg_addr_width = 5;
    localparam int flow_width     = 2;
    localparam int resctrl_width  = 2;

    // --------------------------------------
    // Major opcodes
    // --------------------------------------
    localparam logic [6:0] op_r     = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_jal   = 7'b1101111;

    // --------------------------------------
    // Pipeline flow commands
    // --------------------------------------
    // Code 3 is treated as a refresh
    localparam logic [flow_width-1:0] flow_work    = 2'd0;
    localparam logic [flow_width-1:0] flow_stop    = 2'd1;
    localparam logic [flow_width-1:0] flow_refresh = 2'd2;

    // --------------------------------------
    // Result-control codes
    // --------------------------------------
    // Source of the write-back value, none marks a bubble
    localparam logic [resctrl_width-1:0] resctrl_reg  = 2'd0;
    localparam logic [resctrl_width-1:0] resctrl_mem  = 2'd1;
    localparam logic [resctrl_width-1:0] resctrl_pc   = 2'd2;
    localparam logic [resctrl_width-1:0] resctrl_none = 2'd3;

    // ALU operations
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_pass_b = 3'd6
    } alu_op_e;

    // Instruction word, seen as R/I layout or as S layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } rv_inst_u;

endpackage

/* compile.f */
common/rv_pkg.sv
decode/rv_decode.sv
execute/rv_execute.sv
logic/ex_mem_reg.sv
logic/rv_result.sv
logic/rv_ex_top.sv
tb/rv_ex_props.sv
tb/tb_rv_ex.sv

/* decode/rv_decode.sv */
// --------------------------------------
// RV32I instruction decoder
// Immediate, ALU op and write-back control
// --------------------------------------

`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::cpu_width-1:0]      inst_i,
    output logic [rv_pkg::cpu_width-1:0]      imm_o,
    output rv_pkg::alu_op_e                   alu_op_o,
    output logic                              use_imm_o,
    output logic [rv_pkg::resctrl_width-1:0]  res_op_o,
    output logic                              reg_wr_en_o,
    output logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr_o
);

    rv_pkg::rv_inst_u inst;

    assign inst = inst_i;

    // --------------------------------------
    // Immediate generation
    // --------------------------------------
    always_comb begin
        case (inst.r.opcode)
            rv_pkg::op_imm, rv_pkg::op_load: begin
                imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            rv_pkg::op_store: begin
                imm_o = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            end
            rv_pkg::op_lui: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            rv_pkg::op_jal: begin
                imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

    // --------------------------------------
    // Control decode
    // --------------------------------------
    always_comb begin
        alu_op_o    = rv_pkg::alu_add;
        use_imm_o   = 1'b0;
        res_op_o    = rv_pkg::resctrl_none;
        reg_wr_en_o = 1'b0;

        case (inst.r.opcode)
            rv_pkg::op_r, rv_pkg::op_imm: begin
                use_imm_o   = (inst.r.opcode == rv_pkg::op_imm);
                res_op_o    = rv_pkg::resctrl_reg;
                reg_wr_en_o = 1'b1;
                case (inst.r.funct3)
                    3'b000: begin
                        // funct7 bit 5 selects sub, only for register ops
                        if (inst.r.opcode == rv_pkg::op_r && inst.r.funct7[5]) begin
                            alu_op_o = rv_pkg::alu_sub;
                        end else begin
                            alu_op_o = rv_pkg::alu_add;
                        end
                    end
                    3'b010:  alu_op_o = rv_pkg::alu_slt;
                    3'b100:  alu_op_o = rv_pkg::alu_xor;
                    3'b110:  alu_op_o = rv_pkg::alu_or;
                    3'b111:  alu_op_o = rv_pkg::alu_and;
                    default: alu_op_o = rv_pkg::alu_add;
                endcase
            end
            rv_pkg::op_lui: begin
                alu_op_o    = rv_pkg::alu_pass_b;
                use_imm_o   = 1'b1;
                res_op_o    = rv_pkg::resctrl_reg;
                reg_wr_en_o = 1'b1;
            end
            rv_pkg::op_load: begin
                use_imm_o   = 1'b1;
                res_op_o    = rv_pkg::resctrl_reg;
                reg_wr_en_o = 1'b1;
            end
            rv_pkg::op_store: begin
                use_imm_o = 1'b1;
                res_op_o  = rv_pkg::resctrl_mem;
            end
            rv_pkg::op_jal: begin
                use_imm_o   = 1'b1;
                res_op_o    = rv_pkg::resctrl_pc;
                reg_wr_en_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Destination only meaningful when a write happens
    assign reg_wr_addr_o = reg_wr_en_o ? inst.r.rd : '0;

endmodule

/* execute/rv_execute.sv */
// --------------------------------------
// RV32I execute unit
// ALU with operand select and link adder
// --------------------------------------

`timescale 1ns/1ps

module rv_execute (
    input  logic [rv_pkg::cpu_width-1:0] rs1_data_i,
    input  logic [rv_pkg::cpu_width-1:0] rs2_data_i,
    input  logic [rv_pkg::cpu_width-1:0] imm_i,
    input  logic [rv_pkg::cpu_width-1:0] pc_i,
    input  rv_pkg::alu_op_e              alu_op_i,
    input  logic                         use_imm_i,
    output logic [rv_pkg::cpu_width-1:0] alu_res_o,
    output logic [rv_pkg::cpu_width-1:0] link_o
);

    logic [rv_pkg::cpu_width-1:0] op_a;
    logic [rv_pkg::cpu_width-1:0] op_b;

    // Operand selection
    assign op_a = rs1_data_i;
    assign op_b = use_imm_i ? imm_i : rs2_data_i;

    // --------------------------------------
    // ALU
    // --------------------------------------
    // Loads and stores arrive as add for the address
    always_comb begin
        case (alu_op_i)
            rv_pkg::alu_add: begin
                alu_res_o = op_a + op_b;
            end
            rv_pkg::alu_sub: begin
                alu_res_o = op_a - op_b;
            end
            rv_pkg::alu_and: begin
                alu_res_o = op_a & op_b;
            end
            rv_pkg::alu_or: begin
                alu_res_o = op_a | op_b;
            end
            rv_pkg::alu_xor: begin
                alu_res_o = op_a ^ op_b;
            end
            rv_pkg::alu_slt: begin
                // Signed compare
                alu_res_o = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::alu_pass_b: begin
                alu_res_o = op_b;
            end
            default: begin
                alu_res_o = '0;
            end
        endcase
    end

    // Return address for JAL
    assign link_o = pc_i + 32'd4;

endmodule

/* logic/ex_mem_reg.sv */
// --------------------------------------
// Execute-to-memory pipeline register
// Work/stop/refresh flow, imem access flags
// --------------------------------------

`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_pkg::flow_width-1:0]     flow_i,
    input  logic                              no_mem_write_i,

    input  logic [rv_pkg::cpu_width-1:0]      inst_i,
    input  logic [rv_pkg::cpu_width-1:0]      rs2_data_i,
    input  logic [rv_pkg::cpu_width-1:0]      link_i,
    input  logic [rv_pkg::cpu_width-1:0]      alu_res_i,
    input  logic [rv_pkg::resctrl_width-1:0]  res_op_i,
    input  logic                              reg_wr_en_i,
    input  logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr_i,

    output logic [rv_pkg::cpu_width-1:0]      inst_o,
    output logic [rv_pkg::cpu_width-1:0]      rs2_data_o,
    output logic [rv_pkg::cpu_width-1:0]      link_o,
    output logic [rv_pkg::cpu_width-1:0]      alu_res_o,
    output logic [rv_pkg::resctrl_width-1:0]  res_op_o,
    output logic                              reg_wr_en_o,
    output logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr_o,

    output logic [1:0]                        instmem_acc_o
);

    logic is_mem_acc;
    logic in_imem_win;

    // --------------------------------------
    // Instruction-memory access flags
    // --------------------------------------
    // Stores, or register results coming from a load
    assign is_mem_acc = (res_op_i == rv_pkg::resctrl_mem) ||
                        ((res_op_i == rv_pkg::resctrl_reg) &&
                         (inst_i[6:0] == rv_pkg::op_load));

    // Instruction memory sits in the lowest 256 MB
    assign in_imem_win = (alu_res_i[31:28] == 4'b0);

    assign instmem_acc_o[0] = is_mem_acc && in_imem_win;
    // Granted only while no data write is in flight
    assign instmem_acc_o[1] = is_mem_acc && in_imem_win && no_mem_write_i;

    // --------------------------------------
    // Stage register
    // --------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_o        <= '0;
            rs2_data_o    <= '0;
            link_o        <= '0;
            alu_res_o     <= '0;
            res_op_o      <= rv_pkg::resctrl_none;
            reg_wr_en_o   <= 1'b0;
            reg_wr_addr_o <= '0;
        end else begin
            case (flow_i)
                rv_pkg::flow_work: begin
                    inst_o        <= inst_i;
                    rs2_data_o    <= rs2_data_i;
                    link_o        <= link_i;
                    alu_res_o     <= alu_res_i;
                    res_op_o      <= res_op_i;
                    reg_wr_en_o   <= reg_wr_en_i;
                    reg_wr_addr_o <= reg_wr_addr_i;
                end
                rv_pkg::flow_stop: begin
                    // Hold everything
                end
                default: begin
                    // Refresh inserts a bubble but keeps alu_res
                    inst_o        <= '0;
                    rs2_data_o    <= '0;
                    link_o        <= '0;
                    res_op_o      <= rv_pkg::resctrl_none;
                    reg_wr_en_o   <= 1'b0;
                    reg_wr_addr_o <= '0;
                end
            endcase
        end
    end

endmodule

/* logic/rv_ex_top.sv */
// --------------------------------------
// RV32I execute side top level
// Decode, execute, EX/MEM register, result
// --------------------------------------

`timescale 1ns/1ps

module rv_ex_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_pkg::cpu_width-1:0]      inst_i,
    input  logic [rv_pkg::cpu_width-1:0]      pc_i,
    input  logic [rv_pkg::cpu_width-1:0]      rs1_data_i,
    input  logic [rv_pkg::cpu_width-1:0]      rs2_data_i,
    input  logic [rv_pkg::cpu_width-1:0]      mem_rd_data_i,
    input  logic [rv_pkg::flow_width-1:0]     flow_i,
    input  logic                              no_mem_write_i,

    output logic [1:0]                        instmem_acc_o,
    output logic                              mem_rd_en_o,
    output logic                              mem_wr_en_o,
    output logic [rv_pkg::cpu_width-1:0]      mem_addr_o,
    output logic [rv_pkg::cpu_width-1:0]      mem_wr_data_o,
    output logic                              reg_wr_en_o,
    output logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr_o,
    output logic [rv_pkg::cpu_width-1:0]      reg_wr_data_o
);

    // Decode outputs
    logic [rv_pkg::cpu_width-1:0]      imm;
    rv_pkg::alu_op_e                   alu_op;
    logic                              use_imm;
    logic [rv_pkg::resctrl_width-1:0]  res_op;
    logic                              reg_wr_en;
    logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr;

    // Execute outputs
    logic [rv_pkg::cpu_width-1:0]      alu_res;
    logic [rv_pkg::cpu_width-1:0]      link;

    // Registered stage
    logic [rv_pkg::cpu_width-1:0]      q_inst;
    logic [rv_pkg::cpu_width-1:0]      q_rs2_data;
    logic [rv_pkg::cpu_width-1:0]      q_link;
    logic [rv_pkg::cpu_width-1:0]      q_alu_res;
    logic [rv_pkg::resctrl_width-1:0]  q_res_op;
    logic                              q_reg_wr_en;
    logic [rv_pkg::reg_addr_width-1:0] q_reg_wr_addr;

    rv_decode u_decode (
        .inst_i        (inst_i),
        .imm_o         (imm),
        .alu_op_o      (alu_op),
        .use_imm_o     (use_imm),
        .res_op_o      (res_op),
        .reg_wr_en_o   (reg_wr_en),
        .reg_wr_addr_o (reg_wr_addr)
    );

    rv_execute u_execute (
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .imm_i      (imm),
        .pc_i       (pc_i),
        .alu_op_i   (alu_op),
        .use_imm_i  (use_imm),
        .alu_res_o  (alu_res),
        .link_o     (link)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .flow_i         (flow_i),
        .no_mem_write_i (no_mem_write_i),
        .inst_i         (inst_i),
        .rs2_data_i     (rs2_data_i),
        .link_i         (link),
        .alu_res_i      (alu_res),
        .res_op_i       (res_op),
        .reg_wr_en_i    (reg_wr_en),
        .reg_wr_addr_i  (reg_wr_addr),
        .inst_o         (q_inst),
        .rs2_data_o     (q_rs2_data),
        .link_o         (q_link),
        .alu_res_o      (q_alu_res),
        .res_op_o       (q_res_op),
        .reg_wr_en_o    (q_reg_wr_en),
        .reg_wr_addr_o  (q_reg_wr_addr),
        .instmem_acc_o  (instmem_acc_o)
    );

    rv_result u_result (
        .inst_i        (q_inst),
        .rs2_data_i    (q_rs2_data),
        .link_i        (q_link),
        .alu_res_i     (q_alu_res),
        .res_op_i      (q_res_op),
        .reg_wr_en_i   (q_reg_wr_en),
        .reg_wr_addr_i (q_reg_wr_addr),
        .mem_rd_data_i (mem_rd_data_i),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .reg_wr_en_o   (reg_wr_en_o),
        .reg_wr_addr_o (reg_wr_addr_o),
        .reg_wr_data_o (reg_wr_data_o)
    );

endmodule

/* logic/rv_result.sv */
// --------------------------------------
// Memory request and write-back select
// --------------------------------------

`timescale 1ns/1ps

module rv_result (
    input  logic [rv_pkg::cpu_width-1:0]      inst_i,
    input  logic [rv_pkg::cpu_width-1:0]      rs2_data_i,
    input  logic [rv_pkg::cpu_width-1:0]      link_i,
    input  logic [rv_pkg::cpu_width-1:0]      alu_res_i,
    input  logic [rv_pkg::resctrl_width-1:0]  res_op_i,
    input  logic                              reg_wr_en_i,
    input  logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr_i,
    input  logic [rv_pkg::cpu_width-1:0]      mem_rd_data_i,

    output logic                              mem_rd_en_o,
    output logic                              mem_wr_en_o,
    output logic [rv_pkg::cpu_width-1:0]      mem_addr_o,
    output logic [rv_pkg::cpu_width-1:0]      mem_wr_data_o,
    output logic                              reg_wr_en_o,
    output logic [rv_pkg::reg_addr_width-1:0] reg_wr_addr_o,
    output logic [rv_pkg::cpu_width-1:0]      reg_wr_data_o
);

    logic is_load;

    assign is_load = (inst_i[6:0] == rv_pkg::op_load);

    // Data memory request
    assign mem_rd_en_o   = is_load;
    assign mem_wr_en_o   = (res_op_i == rv_pkg::resctrl_mem);
    assign mem_addr_o    = alu_res_i;
    assign mem_wr_data_o = rs2_data_i;

    // Write-back, a bubble never writes
    assign reg_wr_en_o   = reg_wr_en_i && (res_op_i != rv_pkg::resctrl_none);
    assign reg_wr_addr_o = reg_wr_addr_i;
    assign reg_wr_data_o = is_load                        ? mem_rd_data_i :
                           (res_op_i == rv_pkg::resctrl_pc) ? link_i        :
                                                            alu_res_i;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute-side testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rv_ex \
    -f compile.f

sim_out=$(./obj_dir/Vtb_rv_ex 2>&1) || true
echo "$sim_out"

if grep -qF "All tests passed!" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* tb/rv_ex_props.sv */
// ----------------------------------------
// EX/MEM register flow properties
// ----------------------------------------

`timescale 1ns/1ps

module rv_ex_props (
    input logic        clk,
    input logic        rst_n,
    input logic [1:0]  flow_i,
    input logic [31:0] inst_o,
    input logic [31:0] rs2_data_o,
    input logic [31:0] link_o,
    input logic [31:0] alu_res_o,
    input logic [1:0]  res_op_o,
    input logic        reg_wr_en_o,
    input logic [4:0]  reg_wr_addr_o
);

    // Refresh, and code 3, leave a bubble
    refresh_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (flow_i == rv_pkg::flow_refresh || flow_i == 2'd3) |=>
            (!reg_wr_en_o && res_op_o == rv_pkg::resctrl_none))
        else $error("EX/MEM register not a bubble after refresh");

    stop_holds_stage: assert property (@(posedge clk) disable iff (!rst_n)
        (flow_i == rv_pkg::flow_stop) |=>
            $stable({inst_o, rs2_data_o, link_o, alu_res_o, res_op_o, reg_wr_en_o,
                     reg_wr_addr_o}))
        else $error("EX/MEM register changed under stop");

endmodule

bind ex_mem_reg rv_ex_props props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flow_i        (flow_i),
    .inst_o        (inst_o),
    .rs2_data_o    (rs2_data_o),
    .link_o        (link_o),
    .alu_res_o     (alu_res_o),
    .res_op_o      (res_op_o),
    .reg_wr_en_o   (reg_wr_en_o),
    .reg_wr_addr_o (reg_wr_addr_o)
);

/* tb/tb_rv_ex.sv */
// ----------------------------------------
// Testbench for the RV32I execute side
// Random instructions checked against a model
// ----------------------------------------

`timescale 1ns/1ps

module tb_rv_ex;

    localparam int num_instr  = 3000;
    localparam int max_cycles = 4000;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] mem_rd_data;
    logic [1:0]  flow;
    logic        no_mem_write;
    logic [1:0]  instmem_acc;
    logic        mem_rd_en;
    logic        mem_wr_en;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic        reg_wr_en;
    logic [4:0]  reg_wr_addr;
    logic [31:0] reg_wr_data;

    // Expected stage inputs for the instruction on the inputs
    logic [31:0] nx_alu;
    logic        nx_alu_known;
    logic [1:0]  nx_res_op;
    logic        nx_wen;
    logic [4:0]  nx_waddr;

    // Model copy of the EX/MEM register
    logic [31:0] m_inst;
    logic [31:0] m_rs2;
    logic [31:0] m_link;
    logic [31:0] m_alu;
    logic        m_alu_known;
    logic [1:0]  m_res_op;
    logic        m_wen;
    logic [4:0]  m_waddr;

    int errors;
    int checks;
    bit done;

    rv_ex_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_i         (inst),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .mem_rd_data_i  (mem_rd_data),
        .flow_i         (flow),
        .no_mem_write_i (no_mem_write),
        .instmem_acc_o  (instmem_acc),
        .mem_rd_en_o    (mem_rd_en),
        .mem_wr_en_o    (mem_wr_en),
        .mem_addr_o     (mem_addr),
        .mem_wr_data_o  (mem_wr_data),
        .reg_wr_en_o    (reg_wr_en),
        .reg_wr_addr_o  (reg_wr_addr),
        .reg_wr_data_o  (reg_wr_data)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic reset_model();
        m_inst      = '0;
        m_rs2       = '0;
        m_link      = '0;
        m_alu       = '0;
        m_alu_known = 1'b1;
        m_res_op    = rv_pkg::resctrl_none;
        m_wen       = 1'b0;
        m_waddr     = '0;
    endtask

    // ----------------------------------------
    // Random instruction and operand draw
    // ----------------------------------------
    task automatic drive_random_inputs();
        int          kind;
        int          fn;
        int          sel;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] simm;
        logic [31:0] op_b;
        logic [2:0]  f3;
        kind        = $urandom_range(14, 0);
        sel         = $urandom_range(99, 0);
        r1          = $urandom();
        r2          = $urandom();
        rs1_data    = $urandom();
        rs2_data    = $urandom();
        pc          = $urandom();
        mem_rd_data = $urandom();
        no_mem_write = r2[31];
        // Pull about half of the loads and stores into the imem window
        if (kind >= 12 && r2[30]) begin
            rs1_data[31:28] = 4'h0;
        end
        simm         = {{20{r1[26]}}, r1[26:15]};
        op_b         = (kind < 6) ? rs2_data : simm;
        nx_alu_known = 1'b1;
        nx_res_op    = rv_pkg::resctrl_reg;
        nx_wen       = 1'b1;
        nx_waddr     = r1[4:0];
        // Kinds 0-5 are add sub and or xor slt, 6-10 their immediate forms
        if (kind < 6) begin
            fn = kind;
        end else if (kind == 6) begin
            fn = 0;
        end else begin
            fn = kind - 5;
        end
        case (fn)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            4:       f3 = 3'b100;
            default: f3 = 3'b010;
        endcase
        case (fn)
            0:       nx_alu = rs1_data + op_b;
            1:       nx_alu = rs1_data - op_b;
            2:       nx_alu = rs1_data & op_b;
            3:       nx_alu = rs1_data | op_b;
            4:       nx_alu = rs1_data ^ op_b;
            default: nx_alu = ($signed(rs1_data) < $signed(op_b)) ? 32'd1 : 32'd0;
        endcase
        if (kind < 6) begin
            inst = {(kind == 1) ? 7'b0100000 : 7'b0000000, r1[14:10], r1[9:5], f3, r1[4:0],
                    rv_pkg::op_r};
        end else if (kind < 11) begin
            inst = {r1[26:15], r1[9:5], f3, r1[4:0], rv_pkg::op_imm};
        end else if (kind == 11) begin
            inst   = {r2[19:0], r1[4:0], rv_pkg::op_lui};
            nx_alu = {r2[19:0], 12'b0};
        end else if (kind == 12) begin
            inst   = {r1[26:15], r1[9:5], 3'b010, r1[4:0], rv_pkg::op_load};
            nx_alu = rs1_data + simm;
        end else if (kind == 13) begin
            inst      = {r1[26:20], r1[14:10], r1[9:5], 3'b010, r1[19:15], rv_pkg::op_store};
            nx_alu    = rs1_data + simm;
            nx_res_op = rv_pkg::resctrl_mem;
            nx_wen    = 1'b0;
            nx_waddr  = '0;
        end else begin
            // JAL only defines the link value
            inst         = {r2[19:0], r1[4:0], rv_pkg::op_jal};
            nx_alu       = '0;
            nx_alu_known = 1'b0;
            nx_res_op    = rv_pkg::resctrl_pc;
        end
        if (sel < 60) begin
            flow = rv_pkg::flow_work;
        end else if (sel < 75) begin
            flow = rv_pkg::flow_stop;
        end else if (sel < 90) begin
            flow = rv_pkg::flow_refresh;
        end else begin
            flow = 2'd3;
        end
    endtask

    // Stage register update at a rising edge
    task automatic update_model();
        case (flow)
            rv_pkg::flow_work: begin
                m_inst      = inst;
                m_rs2       = rs2_data;
                m_link      = pc + 32'd4;
                m_alu       = nx_alu;
                m_alu_known = nx_alu_known;
                m_res_op    = nx_res_op;
                m_wen       = nx_wen;
                m_waddr     = nx_waddr;
            end
            rv_pkg::flow_stop: begin
            end
            default: begin
                m_inst   = '0;
                m_rs2    = '0;
                m_link   = '0;
                m_res_op = rv_pkg::resctrl_none;
                m_wen    = 1'b0;
                m_waddr  = '0;
            end
        endcase
    endtask

    task automatic check_outputs(input string tag);
        logic        is_load;
        logic        exp_wen;
        logic [31:0] exp_wb;
        is_load = (m_inst[6:0] == rv_pkg::op_load);
        exp_wen = m_wen && (m_res_op != rv_pkg::resctrl_none);
        if (is_load) begin
            exp_wb = mem_rd_data;
        end else if (m_res_op == rv_pkg::resctrl_pc) begin
            exp_wb = m_link;
        end else begin
            exp_wb = m_alu;
        end
        check_value({tag, " mem_rd_en"}, 32'(is_load), 32'(mem_rd_en));
        check_value({tag, " mem_wr_en"}, 32'(m_res_op == rv_pkg::resctrl_mem), 32'(mem_wr_en));
        if (m_alu_known) begin
            check_value({tag, " mem_addr"}, m_alu, mem_addr);
        end
        check_value({tag, " mem_wr_data"}, m_rs2, mem_wr_data);
        check_value({tag, " reg_wr_en"}, 32'(exp_wen), 32'(reg_wr_en));
        if (exp_wen) begin
            check_value({tag, " reg_wr_addr"}, 32'(m_waddr), 32'(reg_wr_addr));
        end
        if (is_load || m_res_op == rv_pkg::resctrl_pc || m_alu_known) begin
            check_value({tag, " reg_wr_data"}, exp_wb, reg_wr_data);
        end
    endtask

    // Instruction-memory window flags from the current inputs
    task automatic check_instmem(input string tag);
        logic acc;
        acc = ((nx_res_op == rv_pkg::resctrl_mem) ||
               (nx_res_op == rv_pkg::resctrl_reg && inst[6:0] == rv_pkg::op_load)) &&
              (nx_alu[31:28] == 4'h0);
        check_value({tag, " instmem_acc"}, 32'({acc && no_mem_write, acc}), 32'(instmem_acc));
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst         = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        mem_rd_data  = '0;
        flow         = rv_pkg::flow_stop;
        no_mem_write = 1'b0;
        errors       = 0;
        checks       = 0;
        void'($urandom(32'h6e7c91c0));
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_outputs("reset");
        for (int i = 0; i < num_instr; i++) begin
            @(negedge clk);
            drive_random_inputs();
            #1;
            check_outputs("ex_mem");
            check_instmem("window");
            @(posedge clk);
            update_model();
        end
        done = 1'b1;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin : watchdog
        int n;
        n = 0;
        while (!done && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (!done) begin
            $display("Timeout: stimulus did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

endmodule
